// ==== Bender.yml ====
package:
  name: bru_top

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/bru_pkg.sv
      - hdl/bru_predictor.sv
      - hdl/bru_return_stack.sv
      - hdl/bru_branch_unit.sv
      - hdl/bru_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/bru_top_props.sv
      - tb/tb_bru_top.sv

// ==== bru_top.f ====
+incdir+hdl
hdl/bru_pkg.sv
hdl/bru_predictor.sv
hdl/bru_return_stack.sv
hdl/bru_branch_unit.sv
hdl/bru_top.sv
tb/bru_top_props.sv
tb/tb_bru_top.sv

// ==== hdl/bru_branch_unit.sv ====
// Branch resolution unit

`include "bru_config.svh"
`timescale 1ns/100ps

module bru_branch_unit (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  bru_pkg::id_req_t          id_req_i,
  input  logic [`BRU_XLEN-1:0]      op_a_i,
  input  logic [`BRU_XLEN-1:0]      op_b_i,
  input  logic                      pred_taken_i,
  input  logic [`BRU_XLEN-1:0]      rsb_top_i,
  input  logic                      ex_stall_i,
  input  logic                      st_flush_i,
  input  logic                      late_exc_i,
  output bru_pkg::redirect_t        redirect_o,
  output bru_pkg::cache_req_t       cache_req_o,
  output logic                      bubble_o,
  output bru_pkg::exc_t             exc_o,
  output logic [`BRU_HIST_BITS-1:0] bp_hist_o,
  output bru_pkg::bp_upd_t          bp_upd_o,
  output bru_pkg::rsb_op_t          rsb_op_o
);
  import bru_pkg::*;

  localparam logic [`BRU_XLEN-1:0] PC_INIT = `BRU_PC_INIT;

  logic [`BRU_XLEN-1:0] seq_pc, br_tgt, jal_tgt, jalr_tgt, nxt_pc_c;
  logic                 br_ok, br_cond, is_ret, link_rd;
  logic                 res_bubble, is_branch, taken_c, flush_c;
  logic                 ic_inv_c, dc_clean_c, push_c, pop_c, misaligned_c;
  logic                 flush_q;
  logic [`BRU_XLEN-1:0] nxt_pc_q;
  logic                 upd_valid_q, upd_taken_q;
  logic [`BRU_XLEN-1:0] upd_pc_q;
  logic [`BRU_HIST_BITS-1:0] upd_hist_q;
  logic [`BRU_HIST_BITS:0]   hist_q;

  ////////////////////////////////////////////////////////////////////////////
  // Targets and conditions
  ////////////////////////////////////////////////////////////////////////////

  assign seq_pc   = id_req_i.pc + `BRU_XLEN'(4);
  assign br_tgt   = id_req_i.pc + imm_b(id_req_i.insn);
  assign jal_tgt  = id_req_i.pc + imm_j(id_req_i.insn);
  assign jalr_tgt = (op_a_i + op_b_i) & {{(`BRU_XLEN-1){1'b1}}, 1'b0};

  // A return reads the stack; a call writes it
  assign is_ret  = (id_req_i.insn.f.rd == 5'd0) && is_link_reg(id_req_i.insn.f.rs1);
  assign link_rd = is_link_reg(id_req_i.insn.f.rd);

  always_comb begin
    br_ok   = 1'b1;
    br_cond = 1'b0;
    case (id_req_i.insn.f.funct3)
      F3_BEQ:  br_cond = (op_a_i == op_b_i);
      F3_BNE:  br_cond = (op_a_i != op_b_i);
      F3_BLT:  br_cond = ($signed(op_a_i) < $signed(op_b_i));
      F3_BGE:  br_cond = ($signed(op_a_i) >= $signed(op_b_i));
      F3_BLTU: br_cond = (op_a_i < op_b_i);
      F3_BGEU: br_cond = (op_a_i >= op_b_i);
      default: br_ok = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Resolution
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    res_bubble   = 1'b1;
    is_branch    = 1'b0;
    taken_c      = 1'b0;
    flush_c      = 1'b0;
    ic_inv_c     = 1'b0;
    dc_clean_c   = 1'b0;
    push_c       = 1'b0;
    pop_c        = 1'b0;
    misaligned_c = 1'b0;
    nxt_pc_c     = seq_pc;
    if (!id_req_i.bubble) begin
      case (id_req_i.insn.f.opcode)
        OPC_BRANCH: if (br_ok) begin
          res_bubble   = 1'b0;
          is_branch    = 1'b1;
          taken_c      = br_cond;
          flush_c      = br_cond ^ pred_taken_i;
          nxt_pc_c     = br_cond ? br_tgt : seq_pc;
          misaligned_c = br_cond & (|br_tgt[1:0]);
        end
        OPC_JAL: begin
          res_bubble   = 1'b0;
          taken_c      = 1'b1;
          flush_c      = ~pred_taken_i;
          nxt_pc_c     = jal_tgt;
          misaligned_c = |jal_tgt[1:0];
          push_c       = link_rd;
        end
        OPC_JALR: begin
          res_bubble   = 1'b0;
          taken_c      = 1'b1;
          flush_c      = ~(is_ret && (jalr_tgt == rsb_top_i));
          nxt_pc_c     = jalr_tgt;
          misaligned_c = |jalr_tgt[1:0];
          push_c       = link_rd;
          pop_c        = is_ret;
        end
        OPC_MISC_MEM: if (id_req_i.insn.f.funct3 == F3_FENCE_I) begin
          res_bubble = 1'b0;
          flush_c    = 1'b1;
          ic_inv_c   = 1'b1;
          dc_clean_c = 1'b1;
        end
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_q     <= 1'b1;
      nxt_pc_q    <= PC_INIT;
      bubble_o    <= 1'b1;
      exc_o       <= '0;
      cache_req_o <= '0;
      upd_valid_q <= 1'b0;
      hist_q      <= '0;
    end else begin
      // Pulses only leave in unstalled cycles
      flush_q                   <= flush_c & ~ex_stall_i;
      cache_req_o.ic_invalidate <= ic_inv_c & ~ex_stall_i;
      cache_req_o.dc_clean      <= dc_clean_c & ~ex_stall_i;
      upd_valid_q               <= is_branch & ~ex_stall_i;
      if (!ex_stall_i) begin
        nxt_pc_q <= nxt_pc_c;
      end
      if (late_exc_i) begin
        bubble_o <= 1'b1;
      end else if (!ex_stall_i) begin
        bubble_o <= res_bubble;
      end
      // Younger exceptions die behind a later-stage exception or any flush
      if (late_exc_i || st_flush_i || flush_q) begin
        exc_o <= '0;
      end else if (!ex_stall_i) begin
        exc_o.illegal_insn     <= id_req_i.exc.illegal_insn;
        exc_o.misaligned_fetch <= id_req_i.exc.misaligned_fetch | misaligned_c;
      end
      if (is_branch && !ex_stall_i) begin
        hist_q <= {hist_q[`BRU_HIST_BITS-1:0], taken_c};
      end
    end
  end

  // Training payload
  always_ff @(posedge clk_i) begin
    upd_pc_q    <= id_req_i.pc;
    upd_hist_q  <= bp_hist_o;
    upd_taken_q <= taken_c;
  end

  assign redirect_o.flush  = flush_q;
  assign redirect_o.nxt_pc = nxt_pc_q;

  assign bp_upd_o.valid   = upd_valid_q;
  assign bp_upd_o.pc      = upd_pc_q;
  assign bp_upd_o.history = upd_hist_q;
  assign bp_upd_o.taken   = upd_taken_q;

  // Lookup history leaves out the branch just resolved
  assign bp_hist_o = hist_q[`BRU_HIST_BITS:1];

  assign rsb_op_o.push      = push_c & ~ex_stall_i;
  assign rsb_op_o.pop       = pop_c & ~ex_stall_i;
  assign rsb_op_o.push_addr = seq_pc;

endmodule

// ==== hdl/bru_config.svh ====
// Branch resolution configuration

`ifndef BRU_CONFIG_SVH
`define BRU_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath
////////////////////////////////////////////////////////////////////////////

// Data and address width
`define BRU_XLEN 32

// Next PC presented after reset
`define BRU_PC_INIT 'h200

////////////////////////////////////////////////////////////////////////////
// Prediction structures
////////////////////////////////////////////////////////////////////////////

`define BRU_HIST_BITS 2
`define BRU_BHT_BITS 4
`define BRU_RSB_DEPTH 4

`endif

// ==== hdl/bru_pkg.sv ====
// Branch resolution types

package bru_pkg;

  `include "bru_config.svh"

  // Major opcodes handled by the branch unit
  typedef enum logic [6:0] {
    OPC_MISC_MEM = 7'b0001111,
    OPC_BRANCH   = 7'b1100011,
    OPC_JALR     = 7'b1100111,
    OPC_JAL      = 7'b1101111
  } opc_e;

  // funct3 encodings
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [2:0] F3_BLT     = 3'b100;
  localparam logic [2:0] F3_BGE     = 3'b101;
  localparam logic [2:0] F3_BLTU    = 3'b110;
  localparam logic [2:0] F3_BGEU    = 3'b111;
  localparam logic [2:0] F3_FENCE_I = 3'b001;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction and stage payloads
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } insn_fields_t;

  // Raw word and field view of the same 32 bits
  typedef union packed {
    logic [31:0]  word;
    insn_fields_t f;
  } insn_t;

  typedef struct packed {
    logic illegal_insn;
    logic misaligned_fetch;
  } exc_t;

  typedef struct packed {
    logic                 bubble;
    logic [`BRU_XLEN-1:0] pc;
    insn_t                insn;
    exc_t                 exc;
  } id_req_t;

  typedef struct packed {
    logic                 flush;
    logic [`BRU_XLEN-1:0] nxt_pc;
  } redirect_t;

  typedef struct packed {
    logic ic_invalidate;
    logic dc_clean;
  } cache_req_t;

  // Training record sent to the predictor
  typedef struct packed {
    logic                      valid;
    logic [`BRU_XLEN-1:0]      pc;
    logic [`BRU_HIST_BITS-1:0] history;
    logic                      taken;
  } bp_upd_t;

  typedef struct packed {
    logic                 push;
    logic                 pop;
    logic [`BRU_XLEN-1:0] push_addr;
  } rsb_op_t;

  ////////////////////////////////////////////////////////////////////////////
  // Decode helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [`BRU_XLEN-1:0] imm_b(insn_t insn);
    return {{(`BRU_XLEN-12){insn.word[31]}}, insn.word[7], insn.word[30:25],
            insn.word[11:8], 1'b0};
  endfunction

  function automatic logic [`BRU_XLEN-1:0] imm_j(insn_t insn);
    return {{(`BRU_XLEN-20){insn.word[31]}}, insn.word[19:12], insn.word[20],
            insn.word[30:21], 1'b0};
  endfunction

  // x1 (ra) or x5 (t0)
  function automatic logic is_link_reg(logic [4:0] r);
    return (r == 5'd1) || (r == 5'd5);
  endfunction

endpackage

// ==== hdl/bru_predictor.sv ====
// Gshare branch predictor

`include "bru_config.svh"
`timescale 1ns/100ps

module bru_predictor (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [`BRU_XLEN-1:0]      lookup_pc_i,
  input  logic [`BRU_HIST_BITS-1:0] hist_i,
  output logic                      pred_taken_o,
  input  bru_pkg::bp_upd_t          upd_i
);

  localparam int BHT_BITS = `BRU_BHT_BITS;
  localparam int ENTRIES  = 2 ** BHT_BITS;
  localparam int PAD_BITS = BHT_BITS - `BRU_HIST_BITS;

  logic [1:0]          cnt_q [ENTRIES];
  logic [BHT_BITS-1:0] lkp_idx;
  logic [BHT_BITS-1:0] upd_idx;
  logic [1:0]          upd_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // Index hashing
  ////////////////////////////////////////////////////////////////////////////

  // Word address bits folded with zero-extended history
  assign lkp_idx = lookup_pc_i[BHT_BITS+1:2] ^ {{PAD_BITS{1'b0}}, hist_i};
  assign upd_idx = upd_i.pc[BHT_BITS+1:2] ^ {{PAD_BITS{1'b0}}, upd_i.history};

  // Upper counter bit is the prediction
  assign pred_taken_o = cnt_q[lkp_idx][1];

  ////////////////////////////////////////////////////////////////////////////
  // Counter training
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    upd_cnt = cnt_q[upd_idx];
    if (upd_i.taken) begin
      if (upd_cnt != 2'b11) begin
        upd_cnt = upd_cnt + 2'b01;
      end
    end else begin
      if (upd_cnt != 2'b00) begin
        upd_cnt = upd_cnt - 2'b01;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Weakly not taken
      for (int i = 0; i < ENTRIES; i++) begin
        cnt_q[i] <= 2'b01;
      end
    end else if (upd_i.valid) begin
      cnt_q[upd_idx] <= upd_cnt;
    end
  end

endmodule

// ==== hdl/bru_return_stack.sv ====
// Return address stack

`include "bru_config.svh"
`timescale 1ns/100ps

module bru_return_stack (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  bru_pkg::rsb_op_t     op_i,
  output logic [`BRU_XLEN-1:0] top_o
);

  localparam int DEPTH    = `BRU_RSB_DEPTH;
  localparam int PTR_BITS = $clog2(DEPTH);
  localparam int CNT_BITS = PTR_BITS + 1;

  logic [`BRU_XLEN-1:0] stack_q [DEPTH];
  logic [PTR_BITS-1:0]  ptr_q;
  logic [CNT_BITS-1:0]  cnt_q;

  // Pointer always marks the top entry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
      cnt_q <= '0;
    end else if (op_i.push && !(op_i.pop && cnt_q != '0)) begin
      // Wraps onto the oldest entry when full
      ptr_q <= ptr_q + 1'b1;
      if (cnt_q != CNT_BITS'(DEPTH)) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end else if (op_i.pop && !op_i.push && cnt_q != '0) begin
      ptr_q <= ptr_q - 1'b1;
      cnt_q <= cnt_q - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (op_i.push) begin
      // Push with pop overwrites the top in place
      if (op_i.pop && cnt_q != '0) begin
        stack_q[ptr_q] <= op_i.push_addr;
      end else begin
        stack_q[ptr_q + 1'b1] <= op_i.push_addr;
      end
    end
  end

  assign top_o = (cnt_q == '0) ? '0 : stack_q[ptr_q];

endmodule

// ==== hdl/bru_top.sv ====
// Branch resolution subsystem

`include "bru_config.svh"
`timescale 1ns/100ps

module bru_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  bru_pkg::id_req_t     id_req_i,
  input  logic [`BRU_XLEN-1:0] op_a_i,
  input  logic [`BRU_XLEN-1:0] op_b_i,
  input  logic                 ex_stall_i,
  input  logic                 st_flush_i,
  input  logic                 late_exc_i,
  output bru_pkg::redirect_t   redirect_o,
  output bru_pkg::cache_req_t  cache_req_o,
  output logic                 bubble_o,
  output bru_pkg::exc_t        exc_o
);
  import bru_pkg::*;

  logic                      pred_taken;
  logic [`BRU_HIST_BITS-1:0] bp_hist;
  bp_upd_t                   bp_upd;
  logic [`BRU_XLEN-1:0]      rsb_top;
  rsb_op_t                   rsb_op;

  bru_branch_unit i_branch_unit (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .id_req_i    (id_req_i),
    .op_a_i      (op_a_i),
    .op_b_i      (op_b_i),
    .pred_taken_i(pred_taken),
    .rsb_top_i   (rsb_top),
    .ex_stall_i  (ex_stall_i),
    .st_flush_i  (st_flush_i),
    .late_exc_i  (late_exc_i),
    .redirect_o  (redirect_o),
    .cache_req_o (cache_req_o),
    .bubble_o    (bubble_o),
    .exc_o       (exc_o),
    .bp_hist_o   (bp_hist),
    .bp_upd_o    (bp_upd),
    .rsb_op_o    (rsb_op)
  );

  // Lookup uses the PC of the instruction in decode
  bru_predictor i_predictor (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .lookup_pc_i (id_req_i.pc),
    .hist_i      (bp_hist),
    .pred_taken_o(pred_taken),
    .upd_i       (bp_upd)
  );

  bru_return_stack i_return_stack (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .op_i  (rsb_op),
    .top_o (rsb_top)
  );

endmodule

// ==== tb/bru_top_props.sv ====
// Branch resolution properties

`timescale 1ns/100ps

module bru_top_props (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                ex_stall_i,
  input bru_pkg::redirect_t  redirect_o,
  input bru_pkg::cache_req_t cache_req_o,
  input logic                bubble_o
);

  // Count of failed assertions
  int unsigned fail_cnt = 0;

  // Redirect and bubble stay asserted during reset
  a_reset_state: assert property (@(posedge clk_i) !rst_ni |-> redirect_o.flush && bubble_o)
    else begin
      fail_cnt++;
      $error("flush or bubble low while reset is held");
    end

  // Cache maintenance always comes with a redirect
  a_cache_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cache_req_o.ic_invalidate || cache_req_o.dc_clean) |-> redirect_o.flush)
    else begin
      fail_cnt++;
      $error("cache request without flush");
    end

  // A stalled edge leaves the next PC alone
  a_stall_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ex_stall_i |=> $stable(redirect_o.nxt_pc))
    else begin
      fail_cnt++;
      $error("nxt_pc changed after a stalled edge");
    end

endmodule

bind bru_top bru_top_props i_props (.*);

// ==== tb/tb_bru_top.sv ====
// Branch resolution testbench

`include "bru_config.svh"
`timescale 1ns/100ps

module tb_bru_top;
  import bru_pkg::*;

  localparam int RAND_BRANCHES = 60;
  // Five cycles per random branch plus margin for the directed tests
  localparam int TIMEOUT_CYCLES = RAND_BRANCHES * 5 + 100;

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  id_req_t              id_req_i;
  logic [`BRU_XLEN-1:0] op_a_i, op_b_i;
  logic                 ex_stall_i, st_flush_i, late_exc_i;
  redirect_t            redirect_o;
  cache_req_t           cache_req_o;
  logic                 bubble_o;
  exc_t                 exc_o;

  integer     seed = 79147;
  int         n_errors = 0;
  int         n_tests = 0;
  // Reference predictor counters and history with one extra newest bit
  logic [1:0] bht [16];
  logic [2:0] ghist;

  bru_top i_dut (.*);

  always #2 clk_i = ~clk_i;

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Test failures found");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Encoders and reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] enc_branch(logic [2:0] f3, logic [12:0] off);
    return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_jal(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] enc_jalr(logic [4:0] rd, logic [4:0] rs1);
    return {12'h000, rs1, 3'b000, rd, 7'b1100111};
  endfunction

  function automatic logic branch_cond(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  // Lookup ignores the newest outcome
  function automatic logic model_pred(logic [31:0] pc);
    return bht[pc[5:2] ^ {2'b00, ghist[2:1]}][1];
  endfunction

  task automatic model_branch(input logic [31:0] pc, input logic taken, output logic pred);
    logic [3:0] idx;
    idx  = pc[5:2] ^ {2'b00, ghist[2:1]};
    pred = bht[idx][1];
    if (taken && bht[idx] != 2'b11) begin
      bht[idx] = bht[idx] + 2'b01;
    end else if (!taken && bht[idx] != 2'b00) begin
      bht[idx] = bht[idx] - 2'b01;
    end
    ghist = {ghist[1:0], taken};
  endtask

  task automatic flag_error(input string msg);
    n_errors++;
    $display("Error at %0d ns: %s", $time, msg);
  endtask

  // One instruction in decode for one edge with outputs read at the falling edge
  task automatic present(input logic [31:0] pc, input logic [31:0] insn, input logic [31:0] a,
                         input logic [31:0] b, input logic [1:0] exc, input logic late);
    @(posedge clk_i);
    id_req_i   <= {1'b0, pc, insn, exc};
    op_a_i     <= a;
    op_b_i     <= b;
    late_exc_i <= late;
    @(posedge clk_i);
    id_req_i.bubble <= 1'b1;
    late_exc_i      <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic expect_redirect(input logic flush, input logic [31:0] nxt);
    if (redirect_o.flush !== flush) begin
      flag_error($sformatf("flush %b, expected %b", redirect_o.flush, flush));
    end
    if (redirect_o.nxt_pc !== nxt) begin
      flag_error($sformatf("nxt_pc %h, expected %h", redirect_o.nxt_pc, nxt));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    n_tests++;
    expect_redirect(1'b1, 32'h200);
    if (bubble_o !== 1'b1) flag_error("bubble_o low after reset");
    if (cache_req_o !== 2'b00 || exc_o !== 2'b00) flag_error("cache or exc set after reset");
  endtask

  task automatic test_random_branches();
    logic [2:0]  kinds [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    logic [31:0] pc, a, b, rnd, nxt;
    logic [12:0] off;
    logic        taken, pred;
    n_tests++;
    for (int i = 0; i < RAND_BRANCHES; i++) begin
      pc    = $random(seed) & 32'hFFFF_FFFC;
      a     = $random(seed);
      b     = ((i / 6) % 2 == 0) ? a : $random(seed);
      rnd   = $random(seed);
      off   = {rnd[12:1], 1'b0};
      taken = branch_cond(kinds[i % 6], a, b);
      nxt   = taken ? pc + {{19{off[12]}}, off} : pc + 32'd4;
      model_branch(pc, taken, pred);
      present(pc, enc_branch(kinds[i % 6], off), a, b, 2'b00, 1'b0);
      expect_redirect(taken ^ pred, nxt);
      if (bubble_o !== 1'b0) flag_error("bubble_o set on a resolved branch");
      @(posedge clk_i);
    end
  endtask

  task automatic test_jumps();
    logic pred;
    n_tests++;
    pred = model_pred(32'h1000);
    present(32'h1000, enc_jal(5'd1, 21'h40), '0, '0, 2'b00, 1'b0);
    expect_redirect(~pred, 32'h1040);
    present(32'h1040, enc_jalr(5'd0, 5'd1), 32'h1000, 32'h4, 2'b00, 1'b0);
    expect_redirect(1'b0, 32'h1004);
    pred = model_pred(32'h2000);
    present(32'h2000, enc_jal(5'd1, 21'h100), '0, '0, 2'b00, 1'b0);
    expect_redirect(~pred, 32'h2100);
    // Indirect jump through x2 to the stacked address with an odd sum
    present(32'h2100, enc_jalr(5'd0, 5'd2), 32'h2001, 32'h4, 2'b00, 1'b0);
    expect_redirect(1'b1, 32'h2004);
    // Return to an address other than the pushed one
    present(32'h2004, enc_jalr(5'd0, 5'd1), 32'h3000, '0, 2'b00, 1'b0);
    expect_redirect(1'b1, 32'h3000);
  endtask

  task automatic test_fence();
    n_tests++;
    present(32'h3000, 32'h0000_100F, '0, '0, 2'b00, 1'b0);
    expect_redirect(1'b1, 32'h3004);
    if (cache_req_o !== 2'b11) flag_error("cache requests missing on FENCE.I");
    @(negedge clk_i);
    if (redirect_o.flush !== 1'b0 || cache_req_o !== 2'b00) begin
      flag_error("FENCE.I flush or cache request longer than one cycle");
    end
    present(32'h3100, 32'h0FF0_000F, '0, '0, 2'b00, 1'b0);
    expect_redirect(1'b0, 32'h3104);
    if (bubble_o !== 1'b1) flag_error("bubble_o low on plain FENCE");
  endtask

  task automatic test_exceptions();
    logic pred;
    n_tests++;
    model_branch(32'h5000, 1'b1, pred);
    present(32'h5000, enc_branch(3'b000, 13'd6), 32'd7, 32'd7, 2'b00, 1'b0);
    expect_redirect(~pred, 32'h5006);
    if (exc_o !== 2'b01) flag_error($sformatf("exc_o %b, expected misaligned fetch", exc_o));
    present(32'h5100, 32'h0FF0_000F, '0, '0, 2'b10, 1'b0);
    if (exc_o !== 2'b10) flag_error($sformatf("exc_o %b, expected illegal insn", exc_o));
    present(32'h5200, 32'h0000_100F, '0, '0, 2'b10, 1'b1);
    if (exc_o !== 2'b00 || bubble_o !== 1'b1) flag_error("late exception did not kill result");
  endtask

  task automatic test_stall();
    logic [31:0] hold_pc, a, nxt;
    logic        hold_bubble, pred, taken;
    n_tests++;
    // Outcome opposite to the prediction so that an unstalled edge would flush
    taken = ~model_pred(32'h6000);
    a     = taken ? 32'd5 : 32'd9;
    nxt   = taken ? 32'h6020 : 32'h6004;
    model_branch(32'h6000, taken, pred);
    @(posedge clk_i);
    id_req_i   <= {1'b0, 32'h6000, enc_branch(3'b110, 13'h20), 2'b00};
    op_a_i     <= a;
    op_b_i     <= 32'd9;
    ex_stall_i <= 1'b1;
    @(negedge clk_i);
    hold_pc     = redirect_o.nxt_pc;
    hold_bubble = bubble_o;
    repeat (3) begin
      @(negedge clk_i);
      expect_redirect(1'b0, hold_pc);
      if (bubble_o !== hold_bubble) flag_error("bubble_o changed during stall");
    end
    @(posedge clk_i);
    ex_stall_i <= 1'b0;
    @(posedge clk_i);
    id_req_i.bubble <= 1'b1;
    @(negedge clk_i);
    expect_redirect(taken ^ pred, nxt);
  endtask

  initial begin
    rst_ni     = 1'b1;
    id_req_i   = '0;
    op_a_i     = '0;
    op_b_i     = '0;
    ex_stall_i = 1'b0;
    st_flush_i = 1'b0;
    late_exc_i = 1'b0;
    id_req_i.bubble = 1'b1;
    ghist = '0;
    for (int i = 0; i < 16; i++) begin
      bht[i] = 2'b01;
    end
    #1 rst_ni = 1'b0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    test_reset();
    test_random_branches();
    test_jumps();
    test_fence();
    test_exceptions();
    test_stall();
    repeat (2) @(posedge clk_i);
    $display("Tests run: %0d, check errors: %0d, assertion errors: %0d",
             n_tests, n_errors, i_dut.i_props.fail_cnt);
    if (n_errors == 0 && i_dut.i_props.fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
